// ==== hdl/fifoCfgPkg.sv ====
// ----------------------------------------------------------
// fifo configuration package
// default geometry of the dual-clock FIFO and the helper
// that turns a depth into an address width
// ----------------------------------------------------------
`default_nettype none

package fifoCfgPkg;

	// default number of storage words, power of two
	localparam int cDefFifoDepth = 16;
	// default payload width in bits
	localparam int cDefDataWidth = 8;
	// alert rises at half fill
	localparam int cDefAlertLevel = cDefFifoDepth / 2;

	// log2 of a power-of-two depth, at least one bit
	function automatic int fAddrWidth(input int depth);
		int width;
		width = 1;
		while ((1 << width) < depth)
		begin
			width++;
		end
		return width;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/fifoCodePkg.sv ====
// ----------------------------------------------------------
// pointer coding package
// fixed-width pointer word and the binary and Gray-code
// conversions used on both clock domain crossings
// ----------------------------------------------------------
`default_nettype none

package fifoCodePkg;

	// widest pointer the helpers handle
	localparam int cCodeMaxWidth = 16;

	// pointer word, binary or Gray
	// callers keep unused upper bits at zero
	typedef logic [cCodeMaxWidth-1:0] codeWordT;

	// adjacent values differ in one bit only
	function automatic codeWordT binToGray(input codeWordT bin);
		return bin ^ (bin >> 1);
	endfunction

	// running xor from the msb down
	function automatic codeWordT grayToBin(input codeWordT gray);
		codeWordT bin;
		bin[cCodeMaxWidth-1] = gray[cCodeMaxWidth-1];
		for (int i = cCodeMaxWidth - 2; i >= 0; i--)
		begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/fifoWriteSide.sv ====
// ----------------------------------------------------------
// FIFO write side
// write pointer and its Gray export, read pointer sync
// into the write clock, full flag and fill-level alert
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fifoWriteSide
	import fifoCfgPkg::*, fifoCodePkg::*;
#(
	parameter int pFifoDepth  = cDefFifoDepth,
	parameter int pAddrWidth  = fAddrWidth(pFifoDepth),
	parameter int pAlertLevel = cDefAlertLevel
)(
	input  wire                  iWCLK,
	input  wire                  inARST,
	// producer request
	input  wire                  iWe,
	// read pointer as Gray code from the read domain
	input  wire [pAddrWidth-1:0] rdGray,
	// to the memory
	output logic [pAddrWidth-1:0] wrAddr,
	output logic                  wrEn,
	// to the read side
	output logic [pAddrWidth-1:0] wrGray,
	// status
	output logic                  oFull,
	output logic                  oRemainCntAlert
);

	// alert threshold at pointer width
	localparam logic [pAddrWidth-1:0] lpAlertLevel = (pAddrWidth)'(pAlertLevel);

	logic [pAddrWidth-1:0] wrAddrNext;
	logic [pAddrWidth-1:0] rdGraySync1;
	logic [pAddrWidth-1:0] rdGraySync2;
	logic [pAddrWidth-1:0] rdAddrSync;
	logic [pAddrWidth-1:0] fillCount;
	codeWordT              wrAddrCode;
	codeWordT              wrGrayCode;
	codeWordT              rdGrayCode;
	codeWordT              rdBinCode;

	// ----------------------------------------------------------
	// write pointer
	// ----------------------------------------------------------
	assign wrAddrNext = wrAddr + 1'b1;

	// accepted write only
	assign wrEn = iWe & ~oFull;

	always_ff @(posedge iWCLK or negedge inARST)
	begin
		if (!inARST)
			wrAddr <= '0;
		else if (wrEn)
			wrAddr <= wrAddrNext;
	end

	// registered Gray export so the crossing sees clean edges
	assign wrAddrCode = codeWordT'(wrAddr);
	assign wrGrayCode = binToGray(wrAddrCode);

	always_ff @(posedge iWCLK or negedge inARST)
	begin
		if (!inARST)
			wrGray <= '0;
		else
			wrGray <= wrGrayCode[pAddrWidth-1:0];
	end

	// ----------------------------------------------------------
	// read pointer crossing
	// ----------------------------------------------------------
	// two flops on iWCLK before the decode
	always_ff @(posedge iWCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			rdGraySync1 <= '0;
			rdGraySync2 <= '0;
		end
		else
		begin
			rdGraySync1 <= rdGray;
			rdGraySync2 <= rdGraySync1;
		end
	end

	assign rdGrayCode = codeWordT'(rdGraySync2);
	assign rdBinCode  = grayToBin(rdGrayCode);
	assign rdAddrSync = rdBinCode[pAddrWidth-1:0];

	// ----------------------------------------------------------
	// status
	// ----------------------------------------------------------
	// one slot kept free so at most depth minus one words
	assign oFull = (wrAddrNext == rdAddrSync);

	// fill seen here overstates while the read pointer lags
	assign fillCount       = wrAddr - rdAddrSync;
	assign oRemainCntAlert = (fillCount >= lpAlertLevel);

	// exported Gray pointer flips at most one bit per cycle
	assert property (@(posedge iWCLK) disable iff (!inARST)
		$onehot0(wrGray ^ $past(wrGray)));

	// pointer moves only after an accepted write
	assert property (@(posedge iWCLK) disable iff (!inARST)
		$changed(wrAddr) |-> $past(wrEn));

endmodule

`default_nettype wire

// ==== hdl/fifoReadSide.sv ====
// ----------------------------------------------------------
// FIFO read side
// read pointer and its Gray export, write pointer sync
// into the read clock, empty flag and read-valid strobe
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fifoReadSide
	import fifoCfgPkg::*, fifoCodePkg::*;
#(
	parameter int pFifoDepth = cDefFifoDepth,
	parameter int pAddrWidth = fAddrWidth(pFifoDepth)
)(
	input  wire                  iRCLK,
	input  wire                  inARST,
	// consumer request
	input  wire                  iRe,
	// write pointer as Gray code from the write domain
	input  wire [pAddrWidth-1:0] wrGray,
	// to the memory
	output logic [pAddrWidth-1:0] rdAddr,
	output logic                  rdEn,
	// to the write side
	output logic [pAddrWidth-1:0] rdGray,
	// status
	output logic                  oEmp,
	output logic                  oRvd
);

	logic [pAddrWidth-1:0] wrGraySync1;
	logic [pAddrWidth-1:0] wrGraySync2;
	logic [pAddrWidth-1:0] wrAddrSync;
	codeWordT              wrGrayCode;
	codeWordT              wrBinCode;
	codeWordT              rdAddrCode;
	codeWordT              rdGrayCode;

	// ----------------------------------------------------------
	// write pointer crossing
	// ----------------------------------------------------------
	// two flops on iRCLK
	always_ff @(posedge iRCLK or negedge inARST)
	begin
		if (!inARST)
		begin
			wrGraySync1 <= '0;
			wrGraySync2 <= '0;
		end
		else
		begin
			wrGraySync1 <= wrGray;
			wrGraySync2 <= wrGraySync1;
		end
	end

	// back to binary for the compare
	assign wrGrayCode = codeWordT'(wrGraySync2);
	assign wrBinCode  = grayToBin(wrGrayCode);
	assign wrAddrSync = wrBinCode[pAddrWidth-1:0];

	// ----------------------------------------------------------
	// read pointer and status
	// ----------------------------------------------------------
	// nothing stored when the pointers meet
	assign oEmp = (wrAddrSync == rdAddr);
	assign rdEn = iRe & ~oEmp;

	always_ff @(posedge iRCLK or negedge inARST)
	begin
		if (!inARST)
			rdAddr <= '0;
		else if (rdEn)
			rdAddr <= rdAddr + 1'b1;
	end

	// Gray export
	assign rdAddrCode = codeWordT'(rdAddr);
	assign rdGrayCode = binToGray(rdAddrCode);

	always_ff @(posedge iRCLK or negedge inARST)
	begin
		if (!inARST)
			rdGray <= '0;
		else
			rdGray <= rdGrayCode[pAddrWidth-1:0];
	end

	// valid lines up with the registered memory output
	always_ff @(posedge iRCLK or negedge inARST)
	begin
		if (!inARST)
			oRvd <= 1'b0;
		else
			oRvd <= rdEn;
	end

	// exported Gray pointer flips at most one bit per cycle
	assert property (@(posedge iRCLK) disable iff (!inARST)
		$onehot0(rdGray ^ $past(rdGray)));

endmodule

`default_nettype wire

// ==== hdl/sdpBram.sv ====
// ----------------------------------------------------------
// simple dual-port memory
// written on the write clock, read on the read clock
// through an enabled output register
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sdpBram
	import fifoCfgPkg::*;
#(
	parameter int pFifoDepth = cDefFifoDepth,
	parameter int pAddrWidth = fAddrWidth(pFifoDepth),
	parameter int pDataWidth = cDefDataWidth
)(
	// write port
	input  wire                  iWCLK,
	input  wire                  wrEn,
	input  wire [pAddrWidth-1:0] wrAddr,
	input  wire [pDataWidth-1:0] iWd,
	// read port
	input  wire                  iRCLK,
	input  wire                  rdEn,
	input  wire [pAddrWidth-1:0] rdAddr,
	output logic [pDataWidth-1:0] oRd
);

	// storage, one word per address
	logic [pDataWidth-1:0] mem [pFifoDepth];

	// ----------------------------------------------------------
	// write port
	// ----------------------------------------------------------
	always_ff @(posedge iWCLK)
	begin
		if (wrEn)
			mem[wrAddr] <= iWd;
	end

	// ----------------------------------------------------------
	// read port
	// ----------------------------------------------------------
	// holds the last word between reads
	always_ff @(posedge iRCLK)
	begin
		if (rdEn)
			oRd <= mem[rdAddr];
	end

	// pointers from both sides must be clean when used
	assert property (@(posedge iWCLK) wrEn |-> !$isunknown(wrAddr));
	assert property (@(posedge iRCLK) rdEn |-> !$isunknown(rdAddr));

endmodule

`default_nettype wire

// ==== hdl/asyncFifoController.sv ====
// ----------------------------------------------------------
// dual-clock FIFO top level
// producer on iWCLK, consumer on iRCLK, pointers cross
// as Gray code, storage in a simple dual-port memory
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module asyncFifoController
	import fifoCfgPkg::*;
#(
	parameter int pFifoDepth  = cDefFifoDepth,
	parameter int pDataWidth  = cDefDataWidth,
	parameter int pAlertLevel = cDefAlertLevel
)(
	// write domain
	input  wire                  iWCLK,
	input  wire [pDataWidth-1:0] iWd,
	input  wire                  iWe,
	output logic                 oFull,
	output logic                 oRemainCntAlert,
	// read domain
	input  wire                  iRCLK,
	input  wire                  iRe,
	output logic [pDataWidth-1:0] oRd,
	output logic                 oRvd,
	output logic                 oEmp,
	// both domains
	input  wire                  inARST
);

	// pointer width from depth
	localparam int pAddrWidth = fAddrWidth(pFifoDepth);

	// write side results
	logic [pAddrWidth-1:0] wrAddr;
	logic [pAddrWidth-1:0] wrGray;
	logic                  wrEn;
	// read side results
	logic [pAddrWidth-1:0] rdAddr;
	logic [pAddrWidth-1:0] rdGray;
	logic                  rdEn;

	// ----------------------------------------------------------
	// write domain
	// ----------------------------------------------------------
	fifoWriteSide #(
		.pFifoDepth  (pFifoDepth),
		.pAddrWidth  (pAddrWidth),
		.pAlertLevel (pAlertLevel)
	) u_writeSide (
		.iWCLK           (iWCLK),
		.inARST          (inARST),
		.iWe             (iWe),
		.rdGray          (rdGray),
		.wrAddr          (wrAddr),
		.wrEn            (wrEn),
		.wrGray          (wrGray),
		.oFull           (oFull),
		.oRemainCntAlert (oRemainCntAlert)
	);

	// ----------------------------------------------------------
	// read domain
	// ----------------------------------------------------------
	fifoReadSide #(
		.pFifoDepth (pFifoDepth),
		.pAddrWidth (pAddrWidth)
	) u_readSide (
		.iRCLK  (iRCLK),
		.inARST (inARST),
		.iRe    (iRe),
		.wrGray (wrGray),
		.rdAddr (rdAddr),
		.rdEn   (rdEn),
		.rdGray (rdGray),
		.oEmp   (oEmp),
		.oRvd   (oRvd)
	);

	// storage joins both sides
	sdpBram #(
		.pFifoDepth (pFifoDepth),
		.pAddrWidth (pAddrWidth),
		.pDataWidth (pDataWidth)
	) u_bram (
		.iWCLK  (iWCLK),
		.wrEn   (wrEn),
		.wrAddr (wrAddr),
		.iWd    (iWd),
		.iRCLK  (iRCLK),
		.rdEn   (rdEn),
		.rdAddr (rdAddr),
		.oRd    (oRd)
	);

endmodule

`default_nettype wire

// ==== dv/fifoChecker.sv ====
// ----------------------------------------------------------
// FIFO checker
// scoreboard queue fed by accepted writes, compares read
// data, valid pulses and settled flags, counts errors
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fifoChecker
	import fifoCfgPkg::*;
#(
	parameter int pDataWidth = cDefDataWidth
)(
	input  wire                  iWCLK,
	input  wire                  iRCLK,
	input  wire                  inARST,
	// write domain, seen at the DUT ports
	input  wire                  iWe,
	input  wire [pDataWidth-1:0] iWd,
	input  wire                  oFull,
	input  wire                  oRemainCntAlert,
	// read domain
	input  wire                  iRe,
	input  wire                  oEmp,
	input  wire                  oRvd,
	input  wire [pDataWidth-1:0] oRd,
	// settled expectations from the stimulus side
	input  wire                  expStrobe,
	input  wire                  expFull,
	input  wire                  expEmp,
	input  wire                  expAlert,
	input  wire [15:0]           expCount,
	output logic [31:0]          errCount
);

	logic [pDataWidth-1:0] scoreboard [$];
	logic [pDataWidth-1:0] expWord;
	// read accepted on the previous iRCLK edge
	logic                  rdAccepted;
	int                    errTotal = 0;

	assign errCount = errTotal;

	task automatic compareFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errTotal++;
			$display("CHECK FAILED %s expected %h got %h", name, exp, got);
		end
	endtask

	// ----------------------------------------------------------
	// write domain
	// ----------------------------------------------------------
	// only accepted writes, dropped ones never enter
	always @(posedge iWCLK)
	begin
		if (inARST === 1'b1 && iWe === 1'b1 && oFull === 1'b0)
			scoreboard.push_back(iWd);
	end

	// ----------------------------------------------------------
	// read domain
	// ----------------------------------------------------------
	always @(posedge iRCLK)
	begin
		if (inARST !== 1'b1)
			rdAccepted = 1'b0;
		else
		begin
			// one valid pulse, one cycle after each accepted read
			compareFlag("oRvd", oRvd, rdAccepted);
			if (oRvd === 1'b1)
			begin
				if (scoreboard.size() == 0)
				begin
					errTotal++;
					$display("read valid pulse arrived with no word left in the scoreboard");
				end
				else
				begin
					expWord = scoreboard.pop_front();
					if (oRd !== expWord)
					begin
						errTotal++;
						$display("CHECK FAILED oRd expected %h got %h", expWord, oRd);
					end
				end
			end
			// settled flags and words still stored
			if (expStrobe === 1'b1)
			begin
				compareFlag("oFull", oFull, expFull);
				compareFlag("oEmp", oEmp, expEmp);
				compareFlag("oRemainCntAlert", oRemainCntAlert, expAlert);
				if (scoreboard.size() != int'(expCount))
				begin
					errTotal++;
					$display("CHECK FAILED stored word count expected %h got %h",
						expCount, scoreboard.size());
				end
			end
			rdAccepted = iRe & ~oEmp;
		end
	end

endmodule

`default_nettype wire

// ==== dv/tbAsyncFifo.sv ====
// ----------------------------------------------------------
// dual-clock FIFO testbench
// clocks and reset, case file reader, LFSR paced write and
// read bursts, settled flag expectations for the checker
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tbAsyncFifo
	import fifoCfgPkg::*;
();

	// read cycles allowed for the flags to settle
	localparam int cSettleLimit = 200;

	logic                     iWCLK;
	logic                     iRCLK;
	logic                     inARST;
	logic                     iWe;
	logic                     iRe;
	logic [cDefDataWidth-1:0] iWd;
	wire  [cDefDataWidth-1:0] oRd;
	wire                      oFull;
	wire                      oRemainCntAlert;
	wire                      oRvd;
	wire                      oEmp;
	logic                     expStrobe;
	logic                     expFull;
	logic                     expEmp;
	logic                     expAlert;
	logic [15:0]              expCount;
	wire  [31:0]              errCount;
	logic [31:0]              lfsrState;
	logic [cDefDataWidth-1:0] wrData [$];
	int                       runErrors;
	int                       fd;

	asyncFifoController u_dut (
		.iWCLK           (iWCLK),
		.iWd             (iWd),
		.iWe             (iWe),
		.oFull           (oFull),
		.oRemainCntAlert (oRemainCntAlert),
		.iRCLK           (iRCLK),
		.iRe             (iRe),
		.oRd             (oRd),
		.oRvd            (oRvd),
		.oEmp            (oEmp),
		.inARST          (inARST)
	);

	fifoChecker #(
		.pDataWidth (cDefDataWidth)
	) u_checker (
		.iWCLK           (iWCLK),
		.iRCLK           (iRCLK),
		.inARST          (inARST),
		.iWe             (iWe),
		.iWd             (iWd),
		.oFull           (oFull),
		.oRemainCntAlert (oRemainCntAlert),
		.iRe             (iRe),
		.oEmp            (oEmp),
		.oRvd            (oRvd),
		.oRd             (oRd),
		.expStrobe       (expStrobe),
		.expFull         (expFull),
		.expEmp          (expEmp),
		.expAlert        (expAlert),
		.expCount        (expCount),
		.errCount        (errCount)
	);

	// ----------------------------------------------------------
	// clocks, unrelated periods
	// ----------------------------------------------------------
	initial
	begin
		iRCLK = 1'b0;
		forever #20 iRCLK = ~iRCLK;
	end

	initial
	begin
		iWCLK = 1'b0;
		forever #14 iWCLK = ~iWCLK;
	end

	// ----------------------------------------------------------
	// pacing
	// ----------------------------------------------------------
	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic nextBit();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	// idle cycles after a transfer, 0 to 3
	function automatic logic [1:0] pickGap();
		logic hi;
		logic lo;
		hi = nextBit();
		lo = nextBit();
		return {hi, lo};
	endfunction

	// words come from wrData, full drops the extras
	task automatic writeBurst(input int n);
		logic [1:0] gap;
		for (int i = 0; i < n; i++)
		begin
			@(posedge iWCLK);
			iWe <= 1'b1;
			iWd <= wrData[i];
			gap = pickGap();
			if (gap != 2'd0)
			begin
				@(posedge iWCLK);
				iWe <= 1'b0;
				repeat (gap - 2'd1) @(posedge iWCLK);
			end
		end
		@(posedge iWCLK);
		iWe <= 1'b0;
	endtask

	// n read slots, ignored by the DUT while empty
	task automatic readBurst(input int n);
		logic [1:0] gap;
		for (int i = 0; i < n; i++)
		begin
			@(posedge iRCLK);
			iRe <= 1'b1;
			gap = pickGap();
			if (gap != 2'd0)
			begin
				@(posedge iRCLK);
				iRe <= 1'b0;
				repeat (gap - 2'd1) @(posedge iRCLK);
			end
		end
		@(posedge iRCLK);
		iRe <= 1'b0;
	endtask

	// wait for settled flags, then one strobe to the checker
	task automatic settleAndExpect(input logic f, input logic e, input logic a,
		input logic [15:0] c);
		int cycles;
		cycles = 0;
		while ((oFull !== f || oEmp !== e || oRemainCntAlert !== a)
			&& cycles < cSettleLimit)
		begin
			@(posedge iRCLK);
			cycles++;
		end
		if (oFull !== f || oEmp !== e || oRemainCntAlert !== a)
		begin
			runErrors++;
			$display("timeout while waiting for full %0d empty %0d alert %0d", f, e, a);
		end
		@(posedge iRCLK);
		expFull   <= f;
		expEmp    <= e;
		expAlert  <= a;
		expCount  <= c;
		expStrobe <= 1'b1;
		@(posedge iRCLK);
		expStrobe <= 1'b0;
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial
	begin
		logic [7:0]               op;
		logic [cDefDataWidth-1:0] d;
		logic [8*160-1:0]         lineBuf;
		logic                     caseDone;
		logic                     ef;
		logic                     ee;
		logic                     ea;
		logic [15:0]              ec;
		int                       n;
		int                       nScan;
		inARST    = 1'b0;
		iWe       = 1'b0;
		iRe       = 1'b0;
		iWd       = '0;
		expStrobe = 1'b0;
		expFull   = 1'b0;
		expEmp    = 1'b0;
		expAlert  = 1'b0;
		expCount  = '0;
		runErrors = 0;
		lfsrState = 32'h77e;
		repeat (2) @(posedge iRCLK);
		inARST <= 1'b1;

		fd = $fopen("dv/fifoCases.txt", "r");
		if (fd == 0)
		begin
			runErrors++;
			$display("could not open the case file dv/fifoCases.txt");
		end
		caseDone = (fd == 0);
		while (!caseDone)
		begin
			op = 8'h00;
			nScan = $fscanf(fd, "%s", op);
			if (nScan != 1)
				caseDone = 1'b1;
			else if (op == "#")
				nScan = $fgets(lineBuf, fd);
			else if (op == "W" || op == "M")
			begin
				nScan = $fscanf(fd, "%d", n);
				wrData.delete();
				for (int i = 0; i < n; i++)
				begin
					nScan = $fscanf(fd, "%h", d);
					wrData.push_back(d);
				end
				if (op == "W")
					writeBurst(n);
				else
				begin
					// both domains busy at once
					fork
						writeBurst(n);
						readBurst(n);
					join
				end
			end
			else if (op == "R")
			begin
				nScan = $fscanf(fd, "%d", n);
				readBurst(n);
			end
			else if (op == "E")
			begin
				nScan = $fscanf(fd, "%d %d %d %d", ef, ee, ea, ec);
				settleAndExpect(ef, ee, ea, ec);
			end
			else
			begin
				runErrors++;
				$display("unknown operation %s in the case file", op);
				caseDone = 1'b1;
			end
		end
		if (fd != 0)
			$fclose(fd);

		repeat (4) @(posedge iRCLK);
		$display("errors: checker %0d, run %0d", errCount, runErrors);
		if (errCount == 0 && runErrors == 0)
		begin
			$display("Verification passed");
		end
		else
		begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== asyncFifoController.f ====
hdl/fifoCfgPkg.sv
hdl/fifoCodePkg.sv
hdl/fifoWriteSide.sv
hdl/fifoReadSide.sv
hdl/sdpBram.sv
hdl/asyncFifoController.sv
dv/fifoChecker.sv
dv/tbAsyncFifo.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the dual-clock FIFO testbench with Verilator and runs it.
# The run fails if the build or the simulation fails, or if the
# simulation log holds the fail message.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tbAsyncFifo -f asyncFifoController.f \
	-o simAsyncFifo > build.log 2>&1 \
	&& ./obj_dir/simAsyncFifo > sim.log 2>&1 \
	&& ! grep -q "Verification failed" sim.log \
	&& echo "simulation run clean, see sim.log" \
	|| { echo "simulation run failed, see build.log and sim.log"; exit 1; }

// ==== dv/fifoCases.txt ====
# W n d..: write n hex words, R n: n read slots, M n d..: W and R with n at once
# E full emp alert stored: settle, then check flags and scoreboard word count
E 0 1 0 0
W 4 11 22 33 44
E 0 0 0 4
R 6
E 0 1 0 0
R 3
E 0 1 0 0
W 19 a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae af b0 b1 b2
E 1 0 1 15
R 20
E 0 1 0 0
W 8 c0 c1 c2 c3 c4 c5 c6 c7
E 0 0 1 8
W 3 c8 c9 ca
R 4
E 0 0 0 7
M 12 d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 da db
R 30
E 0 1 0 0
